// File: verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int word_w    = 16;
    localparam int reg_count = 16;

    typedef logic [word_w-1:0] word_t;   // data and instruction word
    typedef logic [3:0]        reg_idx_t;

    typedef enum logic [3:0] {
        op_add  = 4'd0,  op_addi = 4'd1,  op_sub  = 4'd2,  op_subi = 4'd3,
        op_and  = 4'd4,  op_or   = 4'd5,  op_xor  = 4'd6,  op_nor  = 4'd7,
        op_slt  = 4'd8,  op_shl  = 4'd9,  op_shri = 4'd10, op_lw   = 4'd11,
        op_sw   = 4'd12, op_beq  = 4'd13, op_bne  = 4'd14, op_halt = 4'd15
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_nor = 4'd5,
        alu_slt = 4'd6,
        alu_shl = 4'd7,
        alu_shr = 4'd8
    } alu_op_t;

    typedef enum logic [1:0] {
        mem_none  = 2'b00,
        mem_load  = 2'b01,
        mem_store = 2'b10
    } mem_op_t;

    // instruction fields
    localparam int op_msb = 15;
    localparam int op_lsb = 12;
    localparam int rs_msb = 11;
    localparam int rs_lsb = 8;
    localparam int rt_msb = 7;
    localparam int rt_lsb = 4;
    localparam int rd_msb = 3;   // rd and imm4 share the low nibble
    localparam int rd_lsb = 0;

endpackage

// File: verilog/cpu_bus_pkg.sv
package cpu_bus_pkg;

    typedef logic [11:0] apb_addr_t;   // byte address

    // host port registers
    localparam apb_addr_t ctrl_addr   = 12'h000;
    localparam apb_addr_t status_addr = 12'h004;
    localparam apb_addr_t pc_addr     = 12'h008;

    // memory and register windows, one 32-bit slot per word
    localparam apb_addr_t imem_base = 12'h100;
    localparam apb_addr_t dmem_base = 12'h200;
    localparam apb_addr_t regs_base = 12'h300;

    localparam int ctrl_run_bit       = 0;
    localparam int status_running_bit = 0;
    localparam int status_halted_bit  = 1;

endpackage

// File: verilog/word_ram.sv
`timescale 1ns/1ps

module word_ram #(
    parameter type payload_t = logic [15:0],
    parameter int  depth     = 64
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(depth)-1:0] raddr_a,
    input  logic [$clog2(depth)-1:0] raddr_b,
    output payload_t                 rdata_a,
    output payload_t                 rdata_b
);

    payload_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata_a = mem[raddr_a];   // async reads keep the core single cycle
    assign rdata_b = mem[raddr_b];

    assert property (@(posedge clk) we |-> !$isunknown(waddr) && waddr < depth);

endmodule

// File: verilog/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  cpu_isa_pkg::opcode_t opcode,
    output logic                 reg_dst,
    output logic                 alu_src,
    output logic                 mem_to_reg,
    output logic                 reg_write,
    output logic                 beq,
    output logic                 bne,
    output logic                 halt,
    output logic                 imm_signed,
    output cpu_isa_pkg::alu_op_t alu_op,
    output cpu_isa_pkg::mem_op_t mem_op
);
    import cpu_isa_pkg::*;

    always_comb begin
        reg_dst    = 1'b0;       // rt is the destination unless R-type
        alu_src    = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b1;
        beq        = 1'b0;
        bne        = 1'b0;
        halt       = 1'b0;
        imm_signed = 1'b1;
        alu_op     = alu_add;
        mem_op     = mem_none;
        case (opcode)
            op_add:  reg_dst = 1'b1;
            op_addi: alu_src = 1'b1;
            op_sub: begin
                reg_dst = 1'b1;
                alu_op  = alu_sub;
            end
            op_subi: begin
                alu_src = 1'b1;
                alu_op  = alu_sub;
            end
            op_and: begin
                reg_dst = 1'b1;
                alu_op  = alu_and;
            end
            op_or: begin
                reg_dst = 1'b1;
                alu_op  = alu_or;
            end
            op_xor: begin
                reg_dst = 1'b1;
                alu_op  = alu_xor;
            end
            op_nor: begin
                reg_dst = 1'b1;
                alu_op  = alu_nor;
            end
            op_slt: begin
                reg_dst = 1'b1;
                alu_op  = alu_slt;
            end
            op_shl:  alu_op = alu_shl;   // shift amount from rt, result back to rt
            op_shri: begin
                alu_src    = 1'b1;
                imm_signed = 1'b0;
                alu_op     = alu_shr;
            end
            op_lw: begin
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
                mem_op     = mem_load;
            end
            op_sw: begin
                alu_src   = 1'b1;
                reg_write = 1'b0;
                mem_op    = mem_store;
            end
            op_beq: begin
                reg_write = 1'b0;
                beq       = 1'b1;
                alu_op    = alu_sub;   // zero flag gives equality
            end
            op_bne: begin
                reg_write = 1'b0;
                bne       = 1'b1;
                alu_op    = alu_sub;
            end
            default: begin
                reg_write = 1'b0;
                halt      = 1'b1;
            end
        endcase
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_isa_pkg::alu_op_t op,
    input  cpu_isa_pkg::word_t   a,
    input  cpu_isa_pkg::word_t   b,
    output cpu_isa_pkg::word_t   y,
    output logic                 zero
);
    import cpu_isa_pkg::*;

    always_comb begin
        case (op)
            alu_add: y = a + b;
            alu_sub: y = a - b;
            alu_and: y = a & b;
            alu_or:  y = a | b;
            alu_xor: y = a ^ b;
            alu_nor: y = ~(a | b);
            alu_slt: y = word_t'($signed(a) < $signed(b));
            alu_shl: y = a << b[3:0];
            alu_shr: y = a >> b[3:0];   // logical
            default: y = '0;
        endcase
    end

    assign zero = y == '0;

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  we,
    input  cpu_isa_pkg::reg_idx_t waddr,
    input  cpu_isa_pkg::word_t    wdata,
    input  cpu_isa_pkg::reg_idx_t raddr_a,
    input  cpu_isa_pkg::reg_idx_t raddr_b,
    input  cpu_isa_pkg::reg_idx_t raddr_dbg,
    output cpu_isa_pkg::word_t    rdata_a,
    output cpu_isa_pkg::word_t    rdata_b,
    output cpu_isa_pkg::word_t    rdata_dbg
);
    import cpu_isa_pkg::*;

    word_t regs [reg_count];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin   // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a   = regs[raddr_a];
    assign rdata_b   = regs[raddr_b];
    assign rdata_dbg = regs[raddr_dbg];

endmodule

// File: verilog/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
    parameter int imem_depth = 64,
    parameter int dmem_depth = 64
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          start,
    input  logic                          stop,
    input  cpu_isa_pkg::word_t            imem_data,
    output logic [$clog2(imem_depth)-1:0] imem_addr,
    input  cpu_isa_pkg::word_t            dmem_rdata,
    output logic [$clog2(dmem_depth)-1:0] dmem_addr,
    output cpu_isa_pkg::word_t            dmem_wdata,
    output logic                          dmem_we,
    input  cpu_isa_pkg::reg_idx_t         dbg_raddr,
    output cpu_isa_pkg::word_t            dbg_rdata,
    output logic                          running,
    output logic                          halted,
    output logic [$clog2(imem_depth)-1:0] pc
);
    import cpu_isa_pkg::*;

    localparam int iaw = $clog2(imem_depth);
    localparam int daw = $clog2(dmem_depth);

    opcode_t  opcode;
    reg_idx_t rs, rt, rd, waddr;
    logic     reg_dst, alu_src, mem_to_reg, reg_write, beq, bne, halt, imm_signed;
    alu_op_t  alu_op;
    mem_op_t  mem_op;
    word_t    rs_data, rt_data, imm_ext, alu_b, alu_y, wdata;
    logic     zero, taken;
    logic [iaw-1:0] pc_seq, pc_next;

    assign opcode = opcode_t'(imem_data[op_msb:op_lsb]);
    assign rs     = imem_data[rs_msb:rs_lsb];
    assign rt     = imem_data[rt_msb:rt_lsb];
    assign rd     = imem_data[rd_msb:rd_lsb];

    control_unit u_ctrl (
        .opcode(opcode), .reg_dst(reg_dst), .alu_src(alu_src), .mem_to_reg(mem_to_reg),
        .reg_write(reg_write), .beq(beq), .bne(bne), .halt(halt),
        .imm_signed(imm_signed), .alu_op(alu_op), .mem_op(mem_op)
    );

    assign imm_ext = {{(word_w-4){imm_signed & rd[3]}}, rd};
    assign alu_b   = alu_src ? imm_ext : rt_data;

    // zero means rs == rt since control_unit picks a subtract for branches
    alu u_alu (.op(alu_op), .a(rs_data), .b(alu_b), .y(alu_y), .zero(zero));

    assign waddr = reg_dst ? rd : rt;
    assign wdata = mem_to_reg ? dmem_rdata : alu_y;

    register_file u_regs (
        .clk(clk), .arst_n(arst_n), .we(running && reg_write), .waddr(waddr),
        .wdata(wdata), .raddr_a(rs), .raddr_b(rt), .raddr_dbg(dbg_raddr),
        .rdata_a(rs_data), .rdata_b(rt_data), .rdata_dbg(dbg_rdata)
    );

    assign dmem_addr  = alu_y[daw-1:0];   // wraps at dmem_depth
    assign dmem_wdata = rt_data;
    assign dmem_we    = running && mem_op == mem_store;

    assign taken   = (beq && zero) || (bne && !zero);
    assign pc_seq  = pc + 1'b1;
    assign pc_next = taken ? pc_seq + imm_ext[iaw-1:0] : pc_seq;
    assign imem_addr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= '0;
            running <= 1'b0;
            halted  <= 1'b0;
        end else if (start) begin
            pc      <= '0;
            running <= 1'b1;
            halted  <= 1'b0;
        end else if (stop) begin
            running <= 1'b0;
        end else if (running) begin
            if (halt) begin
                running <= 1'b0;   // pc stays on the halt word
                halted  <= 1'b1;
            end else begin
                pc <= pc_next;
            end
        end
    end

    // stores come only from a sw of a running core
    assert property (@(posedge clk) disable iff (!arst_n)
        dmem_we |-> running && !halted && opcode == op_sw);

endmodule

// File: verilog/apb_host_port.sv
`timescale 1ns/1ps

module apb_host_port #(
    parameter int imem_depth = 64,
    parameter int dmem_depth = 64
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  cpu_bus_pkg::apb_addr_t        paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic                          running,
    input  logic                          halted,
    input  logic [$clog2(imem_depth)-1:0] pc,
    input  logic [15:0]                   imem_rdata,
    input  logic [15:0]                   dmem_rdata,
    input  logic [15:0]                   reg_rdata,
    output logic                          imem_we,
    output logic                          dmem_we_host,
    output logic [$clog2(imem_depth > dmem_depth ? imem_depth : dmem_depth)-1:0] host_addr,
    output logic [15:0]                   host_wdata,
    output logic [3:0]                    reg_raddr,
    output logic                          start,
    output logic                          stop
);
    import cpu_bus_pkg::*;

    localparam int haw = $bits(host_addr);

    logic [5:0]  slot;
    logic        sel_ctrl, sel_status, sel_pc, sel_imem, sel_dmem, sel_regs;
    logic        aligned, err, access, wr_ok, rd_wait;
    logic [31:0] rd_mux;

    assign slot    = paddr[7:2];
    assign aligned = paddr[1:0] == 2'b00;

    assign sel_ctrl   = paddr == ctrl_addr;
    assign sel_status = paddr == status_addr;
    assign sel_pc     = paddr == pc_addr;
    assign sel_imem   = paddr[11:8] == imem_base[11:8] && aligned && slot < imem_depth;
    assign sel_dmem   = paddr[11:8] == dmem_base[11:8] && aligned && slot < dmem_depth;
    assign sel_regs   = paddr[11:8] == regs_base[11:8] && aligned && slot < 16;

    // unmapped, read-only register, or memory busy with the core
    assign err = !(sel_ctrl || sel_status || sel_pc || sel_imem || sel_dmem || sel_regs)
               || (pwrite && (sel_status || sel_pc))
               || (pwrite && running && (sel_imem || sel_dmem));

    assign access = psel && penable;
    assign wr_ok  = access && pwrite && !err;

    assign imem_we      = wr_ok && sel_imem;
    assign dmem_we_host = wr_ok && sel_dmem;
    assign start        = wr_ok && sel_ctrl && pwdata[ctrl_run_bit];
    assign stop         = wr_ok && sel_ctrl && !pwdata[ctrl_run_bit];
    assign host_addr    = haw'(slot);
    assign host_wdata   = pwdata[15:0];
    assign reg_raddr    = slot[3:0];

    always_comb begin
        rd_mux = '0;
        if (sel_ctrl) begin
            rd_mux[ctrl_run_bit] = running;
        end else if (sel_status) begin
            rd_mux[status_running_bit] = running;
            rd_mux[status_halted_bit]  = halted;
        end else if (sel_pc) begin
            rd_mux[$bits(pc)-1:0] = pc;
        end else if (sel_imem) begin
            rd_mux[15:0] = imem_rdata;
        end else if (sel_dmem) begin
            rd_mux[15:0] = dmem_rdata;
        end else if (sel_regs) begin
            rd_mux[15:0] = reg_rdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= access && !pwrite && !rd_wait;   // high in the second access cycle
        end
    end

    always_ff @(posedge clk) begin
        if (access && !pwrite && !rd_wait) begin
            prdata <= rd_mux;
        end
    end

    assign pready  = access && (pwrite || rd_wait);
    assign pslverr = pready && err;

    // a completion always follows a setup cycle of the same transfer
    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(pready) |-> psel && penable && $past(psel));

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter int imem_depth = 64,
    parameter int dmem_depth = 64
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  cpu_bus_pkg::apb_addr_t paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr
);
    import cpu_isa_pkg::*;

    localparam int iaw = $clog2(imem_depth);
    localparam int daw = $clog2(dmem_depth);
    localparam int haw = iaw > daw ? iaw : daw;

    logic           imem_we, dmem_we_host, start, stop, running, halted;
    logic           core_dmem_we, dmem_we;
    logic [haw-1:0] host_addr;
    logic [iaw-1:0] imem_addr, pc;
    logic [daw-1:0] core_dmem_addr, dmem_waddr;
    word_t          host_wdata, imem_data, imem_rdata, dmem_rdata_core, dmem_rdata_host;
    word_t          core_dmem_wdata, dmem_wdata, reg_rdata;
    reg_idx_t       reg_raddr;

    apb_host_port #(.imem_depth(imem_depth), .dmem_depth(dmem_depth)) u_host (
        .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .running(running), .halted(halted), .pc(pc),
        .imem_rdata(imem_rdata), .dmem_rdata(dmem_rdata_host), .reg_rdata(reg_rdata),
        .imem_we(imem_we), .dmem_we_host(dmem_we_host), .host_addr(host_addr),
        .host_wdata(host_wdata), .reg_raddr(reg_raddr), .start(start), .stop(stop)
    );

    cpu_core #(.imem_depth(imem_depth), .dmem_depth(dmem_depth)) u_core (
        .clk(clk), .arst_n(arst_n), .start(start), .stop(stop),
        .imem_data(imem_data), .imem_addr(imem_addr), .dmem_rdata(dmem_rdata_core),
        .dmem_addr(core_dmem_addr), .dmem_wdata(core_dmem_wdata), .dmem_we(core_dmem_we),
        .dbg_raddr(reg_raddr), .dbg_rdata(reg_rdata), .running(running),
        .halted(halted), .pc(pc)
    );

    word_ram #(.payload_t(word_t), .depth(imem_depth)) u_imem (
        .clk(clk), .we(imem_we), .waddr(host_addr[iaw-1:0]), .wdata(host_wdata),
        .raddr_a(imem_addr), .raddr_b(host_addr[iaw-1:0]),
        .rdata_a(imem_data), .rdata_b(imem_rdata)
    );

    // core owns the data memory write port while running
    assign dmem_we    = running ? core_dmem_we : dmem_we_host;
    assign dmem_waddr = running ? core_dmem_addr : host_addr[daw-1:0];
    assign dmem_wdata = running ? core_dmem_wdata : host_wdata;

    word_ram #(.payload_t(word_t), .depth(dmem_depth)) u_dmem (
        .clk(clk), .we(dmem_we), .waddr(dmem_waddr), .wdata(dmem_wdata),
        .raddr_a(core_dmem_addr), .raddr_b(host_addr[daw-1:0]),
        .rdata_a(dmem_rdata_core), .rdata_b(dmem_rdata_host)
    );

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;   // release away from the edge
    end

endmodule

// File: bench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_bus_pkg::*;

    localparam int apb_timeout = 8;     // access cycles before giving up
    localparam int poll_limit  = 100;   // status reads while waiting for halt
    localparam int reset_limit = 20;

    logic        clk, arst_n;
    logic        psel, penable, pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;

    int unsigned p_idx[$], d_idx[$], r_idx[$], m_idx[$];
    logic [15:0] p_val[$], d_val[$], r_val[$], m_val[$];

    tb_clock_gen u_clk (.clk(clk), .arst_n(arst_n));

    cpu_top uut (
        .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: actual 0x%h, expected 0x%h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic load_input;
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] idx, val;
        fd = $fopen("bench/cpu_input.txt", "r");
        if (fd == 0) abort_run("cannot open bench/cpu_input.txt");
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %h %h", tag, idx, val);
            if (n == 3 && tag != "#") begin   // comment lines start with #
                case (tag)
                    "P": begin
                        p_idx.push_back(idx);
                        p_val.push_back(val[15:0]);
                    end
                    "D": begin
                        d_idx.push_back(idx);
                        d_val.push_back(val[15:0]);
                    end
                    "R": begin
                        r_idx.push_back(idx);
                        r_val.push_back(val[15:0]);
                    end
                    "M": begin
                        m_idx.push_back(idx);
                        m_val.push_back(val[15:0]);
                    end
                    default: abort_run($sformatf("unknown tag %c in the input file", tag));
                endcase
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_gap;
        int n;
        n = $urandom_range(3);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // starts 1 ns after a rising edge and returns at the same offset
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output int waits);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        #1;   // sample mid cycle
        waits = 0;
        while (pready !== 1'b1) begin
            if (waits >= apb_timeout) begin
                abort_run($sformatf("no pready on the APB access to 0x%h", addr));
            end
            waits++;
            @(posedge clk);
            #2;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        idle_gap();
    endtask

    task automatic write_word(input logic [11:0] addr, input logic [31:0] data,
                              input logic exp_err);
        logic [31:0] unused;
        logic        err;
        int          waits;
        apb_access(1'b1, addr, data, unused, err, waits);
        check_value($sformatf("pslverr on write to 0x%h", addr), err, exp_err);
        check_value("write wait states", waits, 0);
    endtask

    task automatic read_word(input logic [11:0] addr, input logic exp_err,
                             output logic [31:0] data);
        logic err;
        int   waits;
        apb_access(1'b0, addr, 32'h0, data, err, waits);
        check_value($sformatf("pslverr on read of 0x%h", addr), err, exp_err);
        check_value("read wait states", waits, 1);   // pready in the second access cycle
    endtask

    task automatic expect_word(input logic [11:0] addr, input logic [31:0] expected,
                               input string name);
        logic [31:0] data;
        read_word(addr, 1'b0, data);
        check_value(name, data, expected);
    endtask

    initial begin
        logic [31:0] rdata;
        int unsigned halt_idx;
        bit          halt_found;
        int          polls;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(1));
        load_input();

        halt_found = 1'b0;
        halt_idx   = 0;
        foreach (p_val[i]) begin
            if (p_val[i][15:12] == 4'hf) begin
                halt_idx   = p_idx[i];
                halt_found = 1'b1;
            end
        end
        if (!halt_found) abort_run("the input file holds no halt instruction");

        polls = 0;
        while (arst_n !== 1'b1) begin
            if (polls >= reset_limit) abort_run("reset was never released");
            polls++;
            @(posedge clk);
        end
        @(posedge clk);
        #1;

        expect_word(status_addr, 32'h0, "status after reset");
        expect_word(pc_addr, 32'h0, "pc after reset");

        foreach (p_idx[i]) write_word(imem_base + 12'(4 * p_idx[i]), {16'h0, p_val[i]}, 1'b0);
        foreach (d_idx[i]) write_word(dmem_base + 12'(4 * d_idx[i]), {16'h0, d_val[i]}, 1'b0);
        foreach (p_idx[i]) begin
            expect_word(imem_base + 12'(4 * p_idx[i]), {16'h0, p_val[i]},
                        $sformatf("imem[%0d]", p_idx[i]));
        end
        foreach (d_idx[i]) begin
            expect_word(dmem_base + 12'(4 * d_idx[i]), {16'h0, d_val[i]},
                        $sformatf("dmem[%0d] preload", d_idx[i]));
        end

        write_word(ctrl_addr, 32'h1, 1'b0);
        expect_word(status_addr, 32'h1, "status after start");
        polls = 0;
        read_word(status_addr, 1'b0, rdata);
        while (rdata[status_halted_bit] !== 1'b1) begin
            if (polls >= poll_limit) abort_run("the core did not halt in time");
            polls++;
            read_word(status_addr, 1'b0, rdata);
        end
        check_value("status after halt", rdata, 32'h2);
        expect_word(pc_addr, halt_idx, "pc after halt");

        expect_word(regs_base, 32'h0, "r0");
        foreach (r_idx[i]) begin
            expect_word(regs_base + 12'(4 * r_idx[i]), {16'h0, r_val[i]},
                        $sformatf("r%0d", r_idx[i]));
        end
        foreach (m_idx[i]) begin
            expect_word(dmem_base + 12'(4 * m_idx[i]), {16'h0, m_val[i]},
                        $sformatf("dmem[%0d]", m_idx[i]));
        end

        // error responses
        write_word(status_addr, 32'h0, 1'b1);
        read_word(12'h00c, 1'b1, rdata);   // unmapped register
        write_word(ctrl_addr, 32'h1, 1'b0);   // second start
        write_word(imem_base + 12'(4 * p_idx[0]), 32'h0000_f000, 1'b1);
        write_word(ctrl_addr, 32'h0, 1'b0);   // stop
        expect_word(status_addr, 32'h0, "status after stop");
        expect_word(imem_base + 12'(4 * p_idx[0]), {16'h0, p_val[0]},
                    "imem after rejected write");

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: sources.f
verilog/cpu_isa_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/word_ram.sv
verilog/control_unit.sv
verilog/alu.sv
verilog/register_file.sv
verilog/cpu_core.sv
verilog/apb_host_port.sv
verilog/cpu_top.sv
bench/tb_clock_gen.sv
bench/cpu_tb.sv

// File: bench/cpu_input.txt
# tag index value, all hex: P imem word, D dmem preload
# R expected register, M expected dmem word after the run
D 00 1234
D 01 00f0
D 05 8000
P 00 1015
P 01 102d
P 02 0123
P 03 2124
P 04 4125
P 05 5126
P 06 6127
P 07 7138
P 08 8219
P 09 31a7
P 0a b0b1
P 0b 10c4
P 0c 9bc0
P 0d acd9
P 0e c13f
P 0f b0e5
P 10 d111
P 11 10f1
P 12 e111
P 13 1ff3
P 14 e122
P 15 c010
P 16 10d1
P 17 d121
P 18 c0f2
P 19 f000
R 01 0005
R 02 fffd
R 03 0002
R 04 0008
R 05 0005
R 06 fffd
R 07 fff8
R 08 fff8
R 09 0001
R 0a fffe
R 0b 00f0
R 0c 0f00
R 0d 0007
R 0e 8000
R 0f 0003
M 00 1234
M 01 00f0
M 02 0003
M 04 0002
M 05 8000
